// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= decode_stage_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/decode_stage_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage_chk (
  input logic               clock,
  input logic               rst_n,
  input decode_pkg::fetch_t fetch,
  input logic               flush,
  input decode_pkg::issue_t issue
);

  int failures = 0;

  // a strobe with no flush on either edge issues two edges later
  latency_a: assert property (@(posedge clock) disable iff (!rst_n)
    $past(fetch.valid) && !$past(flush) && !flush |=> issue.valid)
  else begin
    failures++;
    $error("issue.valid missing two edges after a fetch strobe");
  end

  origin_a: assert property (@(posedge clock) disable iff (!rst_n)
    issue.valid |-> $past(fetch.valid, 2) && !$past(flush, 2) && !$past(flush))
  else begin
    failures++;
    $error("issue.valid without an unflushed fetch strobe two edges before");
  end

  flush_a: assert property (@(posedge clock) disable iff (!rst_n)
    flush |=> !issue.valid)
  else begin
    failures++;
    $error("issue.valid high on the edge after a flush");
  end

  reset_a: assert property (@(posedge clock) !rst_n |=> !issue.valid)
  else begin
    failures++;
    $error("issue.valid high after a reset edge");
  end

  x0_read_a: assert property (@(posedge clock) disable iff (!rst_n)
    issue.valid |-> (issue.dec.raddr1 != '0 || issue.rdata1 == '0) &&
                    (issue.dec.raddr2 != '0 || issue.rdata2 == '0))
  else begin
    failures++;
    $error("nonzero operand read from x0");
  end

  x0_write_a: assert property (@(posedge clock) disable iff (!rst_n)
    issue.valid && issue.dec.waddr == '0 |-> !issue.dec.wren)
  else begin
    failures++;
    $error("register write enabled for x0");
  end

endmodule

`default_nettype wire

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module decode_stage_tb;

  logic               clock;
  logic               rst_n;
  decode_pkg::fetch_t fetch;
  decode_pkg::wb_t    wb;
  logic               flush;
  decode_pkg::issue_t issue;

  decode_pkg::word_t  lcg_state;
  decode_pkg::word_t  shadow [`DS_REG_COUNT];
  decode_pkg::issue_t exp_q [$];
  decode_pkg::word_t  instr_q [$];
  logic               pend_valid;
  decode_pkg::word_t  pend_instr;
  decode_pkg::word_t  pend_pc;
  decode_pkg::word_t  next_pc;
  int                 errors;
  int                 timeouts;

  decode_stage u_dut (
    .clock (clock),
    .rst_n (rst_n),
    .fetch (fetch),
    .wb    (wb),
    .flush (flush),
    .issue (issue)
  );

  bind decode_stage decode_stage_chk u_chk (
    .clock (clock),
    .rst_n (rst_n),
    .fetch (fetch),
    .flush (flush),
    .issue (issue)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic decode_pkg::word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // low state bits repeat with short periods so the high half comes out first
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  // sign extend the low n bits
  function automatic decode_pkg::word_t sext(input decode_pkg::word_t v, input int n);
    decode_pkg::word_t t;
    t = v << (32 - n);
    return decode_pkg::word_t'($signed(t) >>> (32 - n));
  endfunction

  function automatic decode_pkg::decode_t ref_decode(input decode_pkg::word_t w);
    decode_pkg::decode_t d;
    logic [2:0]          f3;
    logic                rd_nz;
    logic                rs1_nz;
    int                  pos;
    f3 = w[14:12];
    rd_nz = (w[11:7] != 5'd0);
    rs1_nz = (w[19:15] != 5'd0);
    pos = 0;
    d = '0;
    d.waddr = w[11:7];
    d.raddr1 = w[19:15];
    d.raddr2 = w[24:20];
    d.caddr = w[31:20];
    d.valid = 1'b1;
    case (w[6:0])
      `DS_OP_LUI, `DS_OP_AUIPC: begin
        d.lui = (w[6:0] == `DS_OP_LUI);
        d.auipc = (w[6:0] == `DS_OP_AUIPC);
        d.imm = w & 32'hffff_f000;
        d.wren = rd_nz;
      end
      `DS_OP_JAL: begin
        d.jal = 1'b1;
        d.imm = sext({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
        d.wren = rd_nz;
      end
      `DS_OP_JALR: begin
        d.jalr = 1'b1;
        d.imm = sext(w >> 20, 12);
        d.wren = rd_nz;
        d.rden1 = 1'b1;
      end
      `DS_OP_BRANCH: begin
        d.branch = 1'b1;
        d.imm = sext({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.valid = (f3 != 3'd2) && (f3 != 3'd3);
        pos = (f3 < 3'd2) ? int'(f3) : int'(f3) - 2;
        d.bcu_op = decode_pkg::bcu_op_t'(6'h20 >> pos);
      end
      `DS_OP_LOAD: begin
        d.load = 1'b1;
        d.imm = sext(w >> 20, 12);
        d.wren = rd_nz;
        d.rden1 = 1'b1;
        d.valid = (f3 != 3'd3) && (f3 < 3'd6);
        pos = (f3 < 3'd3) ? int'(f3) : int'(f3) - 1;
        d.lsu_op = decode_pkg::lsu_op_t'(8'h80 >> pos);
      end
      `DS_OP_STORE: begin
        d.store = 1'b1;
        d.imm = sext({20'b0, w[31:25], w[11:7]}, 12);
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.valid = (f3 < 3'd3);
        d.lsu_op = decode_pkg::lsu_op_t'(8'h04 >> f3);
      end
      `DS_OP_IMM, `DS_OP_REG: begin
        d.rden2 = (w[6:0] == `DS_OP_REG);
        d.imm = d.rden2 ? '0 : sext(w >> 20, 12);
        d.wren = rd_nz;
        d.rden1 = 1'b1;
        // slot in add, sub, sll, srl, sra, slt, sltu, and, or, xor order
        case (f3)
          3'd0: pos = (d.rden2 && w[30]) ? 1 : 0;
          3'd1: pos = 2;
          3'd2: pos = 5;
          3'd3: pos = 6;
          3'd4: pos = 9;
          3'd5: pos = w[30] ? 4 : 3;
          3'd6: pos = 8;
          default: pos = 7;
        endcase
        d.alu_op = decode_pkg::alu_op_t'(10'h200 >> pos);
      end
      `DS_OP_FENCE: begin
        d.fence = 1'b1;
        d.valid = (f3 == 3'd0);
      end
      `DS_OP_SYSTEM: begin
        d.imm = {27'b0, w[19:15]};
        if (f3 == 3'd0) begin
          d.ecall = (w[31:20] == `DS_SYS_ECALL);
          d.ebreak = (w[31:20] == `DS_SYS_EBREAK);
          d.mret = (w[31:20] == `DS_SYS_MRET);
          d.wfi = (w[31:20] == `DS_SYS_WFI);
          d.valid = d.ecall | d.ebreak | d.mret | d.wfi;
        end else begin
          d.csr = 1'b1;
          d.wren = rd_nz;
          d.rden1 = ~f3[2];
          // swap forms always write while set and clear forms always read
          d.cwren = (f3[1:0] == 2'b01) ? 1'b1 : rs1_nz;
          d.crden = (f3[1:0] == 2'b01) ? rd_nz : 1'b1;
          d.valid = (f3 != 3'd4);
          pos = f3[2] ? int'(f3) - 2 : int'(f3) - 1;
          d.csr_op = decode_pkg::csr_op_t'(6'h20 >> pos);
        end
      end
      default: d.valid = 1'b0;
    endcase
    if (w == `DS_NOP) begin
      d.alu_op = '0;
    end
    return d;
  endfunction

  function automatic decode_pkg::issue_t expect_record(input decode_pkg::word_t w,
                                                       input decode_pkg::word_t pc);
    decode_pkg::issue_t e;
    e.valid = 1'b1;
    e.pc = pc;
    e.dec = ref_decode(w);
    e.rdata1 = e.dec.rden1 ? shadow[e.dec.raddr1] : '0;
    e.rdata2 = e.dec.rden2 ? shadow[e.dec.raddr2] : '0;
    return e;
  endfunction

  // mostly legal encodings of every class with rd and rs1 often forced to x0
  function automatic decode_pkg::word_t draw_instr();
    decode_pkg::word_t r;
    decode_pkg::word_t w;
    r = lcg_next();
    w = lcg_next();
    case (r[3:0])
      4'd0: w[6:0] = `DS_OP_LUI;
      4'd1: w[6:0] = `DS_OP_AUIPC;
      4'd2: w[6:0] = `DS_OP_JAL;
      4'd3: w[6:0] = `DS_OP_JALR;
      4'd4: w[6:0] = `DS_OP_BRANCH;
      4'd5: w[6:0] = `DS_OP_LOAD;
      4'd6: w[6:0] = `DS_OP_STORE;
      4'd7, 4'd8: w[6:0] = `DS_OP_IMM;
      4'd9: w[6:0] = `DS_OP_REG;
      4'd10: w[6:0] = `DS_OP_FENCE;
      4'd11, 4'd12: w[6:0] = `DS_OP_SYSTEM;
      4'd13: begin
        w[19:0] = {13'b0, `DS_OP_SYSTEM};
        case (r[5:4])
          2'd0: w[31:20] = `DS_SYS_ECALL;
          2'd1: w[31:20] = `DS_SYS_EBREAK;
          2'd2: w[31:20] = `DS_SYS_MRET;
          default: w[31:20] = r[6] ? `DS_SYS_WFI : w[31:20];
        endcase
      end
      4'd14: w = lcg_next();
      default: w = `DS_NOP;
    endcase
    if (r[3:0] < 4'd13 && r[8]) begin
      w[11:7] = 5'd0;
    end
    if (r[3:0] < 4'd13 && r[9]) begin
      w[19:15] = 5'd0;
    end
    return w;
  endfunction

  task automatic match_field(input string name, input logic [127:0] got,
                             input logic [127:0] exp, input decode_pkg::word_t w);
    assert (got === exp) else begin
      errors++;
      $display("Error at time %0t: %s of instr %h is %0h, expected %0h",
               $time, name, w, got, exp);
    end
  endtask

  task automatic check_issue();
    decode_pkg::issue_t exp;
    decode_pkg::decode_t d;
    decode_pkg::word_t  w;
    if (issue.valid) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("Error at time %0t: issue record with no fetch behind it", $time);
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        w = instr_q.pop_front();
        d = issue.dec;
        match_field("pc", 128'(issue.pc), 128'(exp.pc), w);
        match_field("valid", 128'(d.valid), 128'(exp.dec.valid), w);
        if (exp.dec.valid) begin
          match_field("imm", 128'(d.imm), 128'(exp.dec.imm), w);
          match_field("fields and enables",
                      128'({d.waddr, d.raddr1, d.raddr2, d.caddr,
                            d.wren, d.rden1, d.rden2, d.cwren, d.crden}),
                      128'({exp.dec.waddr, exp.dec.raddr1, exp.dec.raddr2, exp.dec.caddr,
                            exp.dec.wren, exp.dec.rden1, exp.dec.rden2, exp.dec.cwren,
                            exp.dec.crden}), w);
          match_field("class flags",
                      128'({d.lui, d.auipc, d.jal, d.jalr, d.branch, d.load, d.store,
                            d.csr, d.fence, d.ecall, d.ebreak, d.mret, d.wfi}),
                      128'({exp.dec.lui, exp.dec.auipc, exp.dec.jal, exp.dec.jalr,
                            exp.dec.branch, exp.dec.load, exp.dec.store, exp.dec.csr,
                            exp.dec.fence, exp.dec.ecall, exp.dec.ebreak, exp.dec.mret,
                            exp.dec.wfi}), w);
          match_field("unit ops", 128'({d.alu_op, d.bcu_op, d.lsu_op, d.csr_op}),
                      128'({exp.dec.alu_op, exp.dec.bcu_op, exp.dec.lsu_op,
                            exp.dec.csr_op}), w);
          match_field("rdata1", 128'(issue.rdata1), 128'(exp.rdata1), w);
          match_field("rdata2", 128'(issue.rdata2), 128'(exp.rdata2), w);
          assert ($countones({d.alu_op, d.bcu_op, d.lsu_op, d.csr_op}) <= 1) else begin
            errors++;
            $display("Error at time %0t: instr %h sets more than one unit op bit",
                     $time, w);
          end
        end
      end
    end
  endtask

  // check what issued in one cycle and then drive writeback, flush and fetch
  task automatic run_cycle(input logic fv, input decode_pkg::word_t w, input logic fl,
                           input decode_pkg::wb_t wbv);
    @(negedge clock);
    check_issue();
    wb = wbv;
    if (wbv.wren && wbv.waddr != '0) begin
      shadow[wbv.waddr] = wbv.wdata;
    end
    // the latched item reads its operands in this cycle
    if (pend_valid && !fl) begin
      exp_q.push_back(expect_record(pend_instr, pend_pc));
      instr_q.push_back(pend_instr);
    end
    flush = fl;
    fetch.valid = fv;
    fetch.instr = w;
    fetch.pc = next_pc;
    pend_valid = fv && !fl;
    pend_instr = w;
    pend_pc = next_pc;
    if (fv) begin
      next_pc = next_pc + 32'd4;
    end
  endtask

  initial begin
    decode_pkg::wb_t   wbv;
    decode_pkg::word_t r;
    decode_pkg::word_t w;
    int                wait_cycles;
    rst_n = 1'b0;
    fetch = '0;
    wb = '0;
    flush = 1'b0;
    lcg_state = 32'h2366_8d1e;
    pend_valid = 1'b0;
    pend_instr = '0;
    pend_pc = '0;
    next_pc = 32'h0000_1000;
    errors = 0;
    timeouts = 0;
    for (int i = 0; i < `DS_REG_COUNT; i++) begin
      shadow[i] = '0;
    end
    repeat (2) @(negedge clock);
    rst_n = 1'b1;

    for (int n = 0; n < 800; n++) begin
      r = lcg_next();
      w = draw_instr();
      wbv.wren = r[8] | r[9];
      wbv.waddr = r[14:10];
      wbv.wdata = lcg_next();
      run_cycle(r[1:0] != 2'b00, w, r[7:4] == 4'hf, wbv);
    end

    wait_cycles = 0;
    while ((exp_q.size() != 0 || pend_valid) && wait_cycles < 10) begin
      run_cycle(1'b0, `DS_NOP, 1'b0, '0);
      wait_cycles++;
    end
    if (exp_q.size() != 0 || pend_valid) begin
      timeouts++;
      $display("Timeout: %0d expected issue records never arrived", exp_q.size());
    end

    $display("error counts: value %0d, checker %0d, timeout %0d",
             errors, u_dut.u_chk.failures, timeouts);
    if (errors == 0 && u_dut.u_chk.failures == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== common/decode_macros.svh ====
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define DS_XLEN 32
`define DS_REG_COUNT 32

// major opcodes
`define DS_OP_LUI 7'b0110111
`define DS_OP_AUIPC 7'b0010111
`define DS_OP_JAL 7'b1101111
`define DS_OP_JALR 7'b1100111
`define DS_OP_BRANCH 7'b1100011
`define DS_OP_LOAD 7'b0000011
`define DS_OP_STORE 7'b0100011
`define DS_OP_IMM 7'b0010011
`define DS_OP_REG 7'b0110011
`define DS_OP_FENCE 7'b0001111
`define DS_OP_SYSTEM 7'b1110011

// branch funct3
`define DS_F3_BEQ 3'b000
`define DS_F3_BNE 3'b001
`define DS_F3_BLT 3'b100
`define DS_F3_BGE 3'b101
`define DS_F3_BLTU 3'b110
`define DS_F3_BGEU 3'b111

// size funct3 shared by loads and stores
`define DS_F3_B 3'b000
`define DS_F3_H 3'b001
`define DS_F3_W 3'b010
`define DS_F3_BU 3'b100
`define DS_F3_HU 3'b101

// alu funct3
`define DS_F3_ADD 3'b000
`define DS_F3_SLL 3'b001
`define DS_F3_SLT 3'b010
`define DS_F3_SLTU 3'b011
`define DS_F3_XOR 3'b100
`define DS_F3_SRL 3'b101
`define DS_F3_OR 3'b110
`define DS_F3_AND 3'b111

// system funct3
`define DS_F3_PRIV 3'b000
`define DS_F3_CSRRW 3'b001
`define DS_F3_CSRRS 3'b010
`define DS_F3_CSRRC 3'b011
`define DS_F3_CSRRWI 3'b101
`define DS_F3_CSRRSI 3'b110
`define DS_F3_CSRRCI 3'b111

`define DS_F3_FENCE 3'b000

// funct12 of the privileged system instructions
`define DS_SYS_ECALL 12'h000
`define DS_SYS_EBREAK 12'h001
`define DS_SYS_MRET 12'h302
`define DS_SYS_WFI 12'h105

// addi x0, x0, 0
`define DS_NOP 32'h0000_0013

`endif

// ==== common/decode_pkg.sv ====
`default_nettype none

`include "decode_macros.svh"

package decode_pkg;

  typedef logic [`DS_XLEN-1:0] word_t;
  typedef logic [$clog2(`DS_REG_COUNT)-1:0] reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  typedef struct packed {
    logic alu_add;
    logic alu_sub;
    logic alu_sll;
    logic alu_srl;
    logic alu_sra;
    logic alu_slt;
    logic alu_sltu;
    logic alu_and;
    logic alu_or;
    logic alu_xor;
  } alu_op_t;

  typedef struct packed {
    logic bcu_beq;
    logic bcu_bne;
    logic bcu_blt;
    logic bcu_bge;
    logic bcu_bltu;
    logic bcu_bgeu;
  } bcu_op_t;

  typedef struct packed {
    logic lsu_lb;
    logic lsu_lh;
    logic lsu_lw;
    logic lsu_lbu;
    logic lsu_lhu;
    logic lsu_sb;
    logic lsu_sh;
    logic lsu_sw;
  } lsu_op_t;

  typedef struct packed {
    logic csrrw;
    logic csrrs;
    logic csrrc;
    logic csrrwi;
    logic csrrsi;
    logic csrrci;
  } csr_op_t;

  typedef struct packed {
    word_t     imm;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    csr_addr_t caddr;
    logic      wren;
    logic      rden1;
    logic      rden2;
    logic      cwren;
    logic      crden;
    // instruction class flags
    logic      lui;
    logic      auipc;
    logic      jal;
    logic      jalr;
    logic      branch;
    logic      load;
    logic      store;
    logic      csr;
    logic      fence;
    logic      ecall;
    logic      ebreak;
    logic      mret;
    logic      wfi;
    alu_op_t   alu_op;
    bcu_op_t   bcu_op;
    lsu_op_t   lsu_op;
    csr_op_t   csr_op;
    logic      valid;
  } decode_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
  } fetch_t;

  typedef struct packed {
    logic      wren;
    reg_addr_t waddr;
    word_t     wdata;
  } wb_t;

  typedef struct packed {
    logic    valid;
    word_t   pc;
    decode_t dec;
    word_t   rdata1;
    word_t   rdata2;
  } issue_t;

endpackage

`default_nettype wire

// ==== decoder/decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module decoder (
  input  decode_pkg::word_t   instr,
  output decode_pkg::decode_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_reg;
  logic       nz_rd;
  logic       nz_rs1;

  decode_pkg::word_t imm_c;
  decode_pkg::word_t imm_i;
  decode_pkg::word_t imm_s;
  decode_pkg::word_t imm_b;
  decode_pkg::word_t imm_u;
  decode_pkg::word_t imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign is_reg = (opcode == `DS_OP_REG);
  assign nz_rd = |instr[11:7];
  // also covers a zero zimm, which sits in the rs1 field
  assign nz_rs1 = |instr[19:15];

  assign imm_c = {27'b0, instr[19:15]};
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec = '0;
    dec.waddr = instr[11:7];
    dec.raddr1 = instr[19:15];
    dec.raddr2 = instr[24:20];
    dec.caddr = instr[31:20];
    dec.valid = 1'b1;

    case (opcode)
      `DS_OP_LUI: begin
        dec.imm = imm_u;
        dec.wren = nz_rd;
        dec.lui = 1'b1;
      end
      `DS_OP_AUIPC: begin
        dec.imm = imm_u;
        dec.wren = nz_rd;
        dec.auipc = 1'b1;
      end
      `DS_OP_JAL: begin
        dec.imm = imm_j;
        dec.wren = nz_rd;
        dec.jal = 1'b1;
      end
      `DS_OP_JALR: begin
        dec.imm = imm_i;
        dec.wren = nz_rd;
        dec.rden1 = 1'b1;
        dec.jalr = 1'b1;
      end
      `DS_OP_BRANCH: begin
        dec.imm = imm_b;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.branch = 1'b1;
        case (funct3)
          `DS_F3_BEQ: dec.bcu_op.bcu_beq = 1'b1;
          `DS_F3_BNE: dec.bcu_op.bcu_bne = 1'b1;
          `DS_F3_BLT: dec.bcu_op.bcu_blt = 1'b1;
          `DS_F3_BGE: dec.bcu_op.bcu_bge = 1'b1;
          `DS_F3_BLTU: dec.bcu_op.bcu_bltu = 1'b1;
          `DS_F3_BGEU: dec.bcu_op.bcu_bgeu = 1'b1;
          default: dec.valid = 1'b0;
        endcase
      end
      `DS_OP_LOAD: begin
        dec.imm = imm_i;
        dec.wren = nz_rd;
        dec.rden1 = 1'b1;
        dec.load = 1'b1;
        case (funct3)
          `DS_F3_B: dec.lsu_op.lsu_lb = 1'b1;
          `DS_F3_H: dec.lsu_op.lsu_lh = 1'b1;
          `DS_F3_W: dec.lsu_op.lsu_lw = 1'b1;
          `DS_F3_BU: dec.lsu_op.lsu_lbu = 1'b1;
          `DS_F3_HU: dec.lsu_op.lsu_lhu = 1'b1;
          default: dec.valid = 1'b0;
        endcase
      end
      `DS_OP_STORE: begin
        dec.imm = imm_s;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.store = 1'b1;
        case (funct3)
          `DS_F3_B: dec.lsu_op.lsu_sb = 1'b1;
          `DS_F3_H: dec.lsu_op.lsu_sh = 1'b1;
          `DS_F3_W: dec.lsu_op.lsu_sw = 1'b1;
          default: dec.valid = 1'b0;
        endcase
      end
      `DS_OP_IMM, `DS_OP_REG: begin
        dec.imm = is_reg ? '0 : imm_i;
        dec.wren = nz_rd;
        dec.rden1 = 1'b1;
        dec.rden2 = is_reg;
        case (funct3)
          `DS_F3_ADD: begin
            // sub exists only in the register form
            dec.alu_op.alu_sub = is_reg & instr[30];
            dec.alu_op.alu_add = ~(is_reg & instr[30]);
          end
          `DS_F3_SLL: dec.alu_op.alu_sll = 1'b1;
          `DS_F3_SLT: dec.alu_op.alu_slt = 1'b1;
          `DS_F3_SLTU: dec.alu_op.alu_sltu = 1'b1;
          `DS_F3_XOR: dec.alu_op.alu_xor = 1'b1;
          `DS_F3_SRL: begin
            dec.alu_op.alu_srl = ~instr[30];
            dec.alu_op.alu_sra = instr[30];
          end
          `DS_F3_OR: dec.alu_op.alu_or = 1'b1;
          `DS_F3_AND: dec.alu_op.alu_and = 1'b1;
          default: dec.valid = 1'b0;
        endcase
      end
      `DS_OP_FENCE: begin
        dec.fence = 1'b1;
        if (funct3 != `DS_F3_FENCE) begin
          dec.valid = 1'b0;
        end
      end
      `DS_OP_SYSTEM: begin
        dec.imm = imm_c;
        if (funct3 == `DS_F3_PRIV) begin
          case (instr[31:20])
            `DS_SYS_ECALL: dec.ecall = 1'b1;
            `DS_SYS_EBREAK: dec.ebreak = 1'b1;
            `DS_SYS_MRET: dec.mret = 1'b1;
            `DS_SYS_WFI: dec.wfi = 1'b1;
            default: dec.valid = 1'b0;
          endcase
        end else begin
          dec.csr = 1'b1;
          dec.wren = nz_rd;
          // csr read and write side effects follow the zicsr rules
          case (funct3)
            `DS_F3_CSRRW: begin
              dec.rden1 = 1'b1;
              dec.cwren = 1'b1;
              dec.crden = nz_rd;
              dec.csr_op.csrrw = 1'b1;
            end
            `DS_F3_CSRRS: begin
              dec.rden1 = 1'b1;
              dec.cwren = nz_rs1;
              dec.crden = 1'b1;
              dec.csr_op.csrrs = 1'b1;
            end
            `DS_F3_CSRRC: begin
              dec.rden1 = 1'b1;
              dec.cwren = nz_rs1;
              dec.crden = 1'b1;
              dec.csr_op.csrrc = 1'b1;
            end
            `DS_F3_CSRRWI: begin
              dec.cwren = 1'b1;
              dec.crden = nz_rd;
              dec.csr_op.csrrwi = 1'b1;
            end
            `DS_F3_CSRRSI: begin
              dec.cwren = nz_rs1;
              dec.crden = 1'b1;
              dec.csr_op.csrrsi = 1'b1;
            end
            `DS_F3_CSRRCI: begin
              dec.cwren = nz_rs1;
              dec.crden = 1'b1;
              dec.csr_op.csrrci = 1'b1;
            end
            default: begin
              dec.csr = 1'b0;
              dec.wren = 1'b0;
              dec.valid = 1'b0;
            end
          endcase
        end
      end
      default: dec.valid = 1'b0;
    endcase

    // a true nop does no alu work
    if (instr == `DS_NOP) begin
      dec.alu_op.alu_add = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/decode_pkg.sv
source/fetch_latch.sv
decoder/decoder.sv
source/reg_file.sv
source/issue_reg.sv
source/decode_stage.sv
bench/decode_stage_chk.sv
bench/decode_stage_tb.sv

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  logic               clock,
  input  logic               rst_n,
  input  decode_pkg::fetch_t fetch,
  input  decode_pkg::wb_t    wb,
  input  logic               flush,
  output decode_pkg::issue_t issue
);

  decode_pkg::word_t   instr;
  decode_pkg::word_t   pc;
  logic                valid;
  decode_pkg::decode_t dec;
  decode_pkg::word_t   rdata1;
  decode_pkg::word_t   rdata2;

  fetch_latch u_fetch_latch (
    .clock (clock),
    .rst_n (rst_n),
    .fetch (fetch),
    .flush (flush),
    .instr (instr),
    .pc    (pc),
    .valid (valid)
  );

  decoder u_decoder (
    .instr (instr),
    .dec   (dec)
  );

  reg_file u_reg_file (
    .clock  (clock),
    .rst_n  (rst_n),
    .wb     (wb),
    .raddr1 (dec.raddr1),
    .raddr2 (dec.raddr2),
    .rden1  (dec.rden1),
    .rden2  (dec.rden2),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  issue_reg u_issue_reg (
    .clock  (clock),
    .rst_n  (rst_n),
    .flush  (flush),
    .valid  (valid),
    .pc     (pc),
    .dec    (dec),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .issue  (issue)
  );

endmodule

`default_nettype wire

// ==== source/fetch_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_latch (
  input  logic               clock,
  input  logic               rst_n,
  input  decode_pkg::fetch_t fetch,
  input  logic               flush,
  output decode_pkg::word_t  instr,
  output decode_pkg::word_t  pc,
  output logic               valid
);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else begin
      valid <= fetch.valid & ~flush;
    end
  end

  // idle cycles keep the last fetched word
  always_ff @(posedge clock) begin
    if (fetch.valid) begin
      instr <= fetch.instr;
      pc <= fetch.pc;
    end
  end

endmodule

`default_nettype wire

// ==== source/issue_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_reg (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                flush,
  input  logic                valid,
  input  decode_pkg::word_t   pc,
  input  decode_pkg::decode_t dec,
  input  decode_pkg::word_t   rdata1,
  input  decode_pkg::word_t   rdata2,
  output decode_pkg::issue_t  issue
);

  logic                valid_q;
  decode_pkg::word_t   pc_q;
  decode_pkg::decode_t dec_q;
  decode_pkg::word_t   rdata1_q;
  decode_pkg::word_t   rdata2_q;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid & ~flush;
    end
  end

  // payload only moves with a valid item
  always_ff @(posedge clock) begin
    if (valid) begin
      pc_q <= pc;
      dec_q <= dec;
      rdata1_q <= rdata1;
      rdata2_q <= rdata2;
    end
  end

  always_comb begin
    issue.valid = valid_q;
    issue.pc = pc_q;
    issue.dec = dec_q;
    issue.rdata1 = rdata1_q;
    issue.rdata2 = rdata2_q;
  end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module reg_file (
  input  logic                  clock,
  input  logic                  rst_n,
  input  decode_pkg::wb_t       wb,
  input  decode_pkg::reg_addr_t raddr1,
  input  decode_pkg::reg_addr_t raddr2,
  input  logic                  rden1,
  input  logic                  rden2,
  output decode_pkg::word_t     rdata1,
  output decode_pkg::word_t     rdata2
);

  // x0 has no storage
  decode_pkg::word_t regs [1:`DS_REG_COUNT-1];

  function automatic decode_pkg::word_t read_port(
    input decode_pkg::reg_addr_t addr,
    input logic                  en
  );
    decode_pkg::word_t data;
    if (!en || addr == '0) begin
      data = '0;
    end else if (wb.wren && wb.waddr == addr) begin
      // same cycle writeback is forwarded
      data = wb.wdata;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < `DS_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wren && wb.waddr != '0) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  always_comb begin
    rdata1 = read_port(raddr1, rden1);
    rdata2 = read_port(raddr2, rden2);
  end

endmodule

`default_nettype wire
